//--- hpt_defines.svh
`ifndef HPT_DEFINES_SVH
`define HPT_DEFINES_SVH

// Width of a virtual or physical address
`define HPT_VADR_BITS 32

// Page offset width, 4 KB pages
`define HPT_PAGE_BITS 12

// Table index width, the table holds 1 << HPT_INDEX_BITS entries
`define HPT_INDEX_BITS 8

// Width of the bounce count and of the bounce limit
`define HPT_BOUNCE_BITS 8

`endif

//--- hpt_pkg.sv
`include "hpt_defines.svh"

package hpt_pkg;

	// ========================================================================
	// Address and index vectors
	// ========================================================================

	typedef logic [`HPT_VADR_BITS-1:0] vadr_t;
	typedef logic [`HPT_VADR_BITS-1:0] padr_t;

	// Page numbers are the address with the page offset stripped off
	typedef logic [`HPT_VADR_BITS-`HPT_PAGE_BITS-1:0] vpn_t;
	typedef logic [`HPT_VADR_BITS-`HPT_PAGE_BITS-1:0] ppn_t;

	typedef logic [`HPT_INDEX_BITS-1:0] hpt_index_t;

	// Used both for the running probe count and for the programmed limit
	typedef logic [`HPT_BOUNCE_BITS-1:0] bounce_t;

	// ========================================================================
	// Bundles
	// ========================================================================

	// One slot of the hashed page table
	// The tag holds the full VPN so that linear probing can tell slots apart
	typedef struct packed {
		logic valid;
		vpn_t tag;
		ppn_t ppn;
	} hpt_entry_t;

	// A single probe, the slot to read and the VPN it must match
	typedef struct packed {
		hpt_index_t index;
		vpn_t       vpn;
	} probe_t;

	// Result of a walk, qualified by done
	// Exactly one of hit and fault is set, padr only means something on a hit
	typedef struct packed {
		logic  hit;
		logic  fault;
		padr_t padr;
	} walk_rsp_t;

	// Walk sequencing in the match engine
	typedef enum logic [1:0] {
		IDLE,
		READ,
		CHECK
	} walk_state_e;

endpackage

//--- ht_bounce_counter.sv
`timescale 1ns/1ps

module ht_bounce_counter (
	input  logic             clk,
	input  logic             rst,
	input  hpt_pkg::bounce_t max_bounce,
	input  logic             xlat,
	input  logic             found,
	input  hpt_pkg::vadr_t   vadr,
	output hpt_pkg::bounce_t count,
	output logic             last_probe,
	output logic             cd_vadr
);
	import hpt_pkg::*;

	// Address seen on the previous cycle, used to spot a new walk target
	vadr_t   vadr_q;
	// Probes already spent on the current address
	bounce_t count_q;

	// ========================================================================
	// Address change detect
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			vadr_q <= '0;
		end else begin
			vadr_q <= vadr;
		end
	end

	// Goes high for exactly one cycle when the requester moves to a new address
	assign cd_vadr = (vadr_q != vadr);

	// A new address starts probing at its home slot right away,
	// so the stale count is hidden in the same cycle as the change
	assign count = cd_vadr ? '0 : count_q;

	// The probe now being issued is the final one the limit allows
	assign last_probe = (count == max_bounce);

	// ========================================================================
	// Bounce count
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
		end else if (cd_vadr) begin
			count_q <= '0;
		end else if (xlat) begin
			if (found) begin
				// Walk finished with a hit so the next walk starts at home
				count_q <= '0;
			end else if (count_q == max_bounce) begin
				// Out of probes, wrap so a retry of the same address starts over
				count_q <= '0;
			end else begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	// The count must stay inside the window the requester allowed
	assert property (@(posedge clk) disable iff (rst)
		$past(!rst) |-> (count_q <= max_bounce))
		else $error("bounce count %0d beyond limit %0d", count_q, max_bounce);

endmodule

//--- hpt_probe_gen.sv
`timescale 1ns/1ps

module hpt_probe_gen (
	input  hpt_pkg::vadr_t   vadr,
	input  hpt_pkg::bounce_t count,
	output hpt_pkg::probe_t  probe
);
	import hpt_pkg::*;

	// Page number of the requested address
	vpn_t       vpn;
	// Home slot of the page number before any bouncing
	hpt_index_t hash;

	// ========================================================================
	// Hash fold
	// ========================================================================

	// Strip the page offset off the virtual address
	assign vpn = vadr[$bits(vadr_t)-1 -: $bits(vpn_t)];

	// XOR fold of the VPN into index-wide chunks
	// Bit b lands in index bit b mod the index width, which is the same as
	// XOR of bits 7:0, 15:8 and the zero extended top nibble for 20 bits
	always_comb begin
		hash = '0;
		for (int b = 0; b < $bits(vpn_t); b++) begin
			hash[b % $bits(hpt_index_t)] = hash[b % $bits(hpt_index_t)] ^ vpn[b];
		end
	end

	// ========================================================================
	// Linear probe
	// ========================================================================

	// Each bounce steps one slot further, the sum wraps with the table size
	assign probe.index = hash + hpt_index_t'(count);

	// The VPN travels with the probe so the match engine compares the right tag
	assign probe.vpn = vpn;

endmodule

//--- hpt_table.sv
`timescale 1ns/1ps

module hpt_table (
	input  logic                clk,
	input  logic                rst,
	input  logic                we,
	input  hpt_pkg::hpt_index_t wr_index,
	input  hpt_pkg::hpt_entry_t wr_entry,
	input  logic                rd_en,
	input  hpt_pkg::hpt_index_t rd_index,
	output hpt_pkg::hpt_entry_t rd_entry
);
	import hpt_pkg::*;

	// One entry per index value
	localparam int DEPTH = 1 << $bits(hpt_index_t);

	// Table storage, loaded by software through the write strobe
	hpt_entry_t mem [DEPTH];

	// ========================================================================
	// Write port
	// ========================================================================

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_index] <= wr_entry;
		end
	end

	// ========================================================================
	// Read port
	// ========================================================================

	// Data shows up the cycle after rd_en and holds until the next read
	// Reset leaves an invalid entry so a stray compare can never hit
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_entry <= '0;
		end else if (rd_en) begin
			rd_entry <= mem[rd_index];
		end
	end

	// Loads are only legal while the walker is idle
	assert property (@(posedge clk) disable iff (rst) !(we && rd_en))
		else $error("table write at slot %0d during a walk read", wr_index);

endmodule

//--- hpt_match_fsm.sv
`timescale 1ns/1ps
`include "hpt_defines.svh"

module hpt_match_fsm (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  hpt_pkg::probe_t     probe,
	input  hpt_pkg::vadr_t      vadr,
	input  logic                cd_vadr,
	input  logic                last_probe,
	output logic                rd_en,
	output logic                xlat,
	output logic                found,
	output logic                done,
	output hpt_pkg::walk_rsp_t  rsp,
	input  hpt_pkg::hpt_entry_t entry
);
	import hpt_pkg::*;

	walk_state_e state;
	walk_state_e state_nxt;

	// VPN and page offset captured with the read, compared one cycle later
	vpn_t                      vpn_q;
	logic [`HPT_PAGE_BITS-1:0] offset_q;

	// Entry from the table matches the probe that fetched it
	logic hit;
	// CHECK cycle that still belongs to the current address
	logic check_live;
	// This check ends the walk, either found or out of probes
	logic finish;

	// ========================================================================
	// Compare
	// ========================================================================

	assign hit        = entry.valid && (entry.tag == vpn_q);
	assign check_live = (state == CHECK) && !cd_vadr;
	assign finish     = check_live && (hit || last_probe);

	// The table read is issued from READ and lands in CHECK
	assign rd_en = (state == READ);

	// Every completed check is reported to the bounce counter
	// A miss advances or wraps the count, a hit clears it for the next walk
	// An abandoned check reports nothing since the counter clears on its own
	assign xlat  = check_live;
	assign found = check_live && hit;

	// ========================================================================
	// State sequencing
	// ========================================================================

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_nxt = READ;
				end
			end
			READ: begin
				// A change here is already folded into the probe, so just go on
				state_nxt = CHECK;
			end
			CHECK: begin
				if (cd_vadr) begin
					// New address, restart from its home slot
					state_nxt = READ;
				end else if (hit || last_probe) begin
					state_nxt = IDLE;
				end else begin
					state_nxt = READ;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Probe details are captured alongside the table read
	always_ff @(posedge clk) begin
		if (state == READ) begin
			vpn_q    <= probe.vpn;
			offset_q <= vadr[`HPT_PAGE_BITS-1:0];
		end
	end

	// ========================================================================
	// Response
	// ========================================================================

	// done is registered, so it lands one cycle after the deciding CHECK
	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= finish;
		end
	end

	// The response only changes when a walk ends and stays put afterwards
	always_ff @(posedge clk) begin
		if (finish) begin
			rsp.hit   <= hit;
			rsp.fault <= !hit;
			rsp.padr  <= {entry.ppn, offset_q};
		end
	end

	// Only one walk is in flight, so a new request may only arrive between walks
	assert property (@(posedge clk) disable iff (rst) req |-> (state == IDLE))
		else $error("request arrived while a walk was still in flight");

endmodule

//--- hpt_lookup.sv
`timescale 1ns/1ps

module hpt_lookup (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  hpt_pkg::vadr_t      vadr,
	input  hpt_pkg::bounce_t    max_bounce,
	input  logic                tbl_we,
	input  hpt_pkg::hpt_index_t tbl_index,
	input  hpt_pkg::hpt_entry_t tbl_entry,
	output logic                done,
	output hpt_pkg::walk_rsp_t  rsp
);
	import hpt_pkg::*;

	// Bounce counter outputs
	bounce_t    count;
	logic       last_probe;
	logic       cd_vadr;

	// Match engine outputs
	logic       xlat;
	logic       found;
	logic       rd_en;

	// Probe from the hash and the entry it fetched
	probe_t     probe;
	hpt_entry_t rd_entry;

	// ========================================================================
	// Probe path
	// ========================================================================

	// Tracks how far the current address has bounced
	ht_bounce_counter u_bounce (
		.clk        (clk),
		.rst        (rst),
		.max_bounce (max_bounce),
		.xlat       (xlat),
		.found      (found),
		.vadr       (vadr),
		.count      (count),
		.last_probe (last_probe),
		.cd_vadr    (cd_vadr)
	);

	hpt_probe_gen u_probe (
		.vadr  (vadr),
		.count (count),
		.probe (probe)
	);

	hpt_table u_table (
		.clk      (clk),
		.rst      (rst),
		.we       (tbl_we),
		.wr_index (tbl_index),
		.wr_entry (tbl_entry),
		.rd_en    (rd_en),
		.rd_index (probe.index),
		.rd_entry (rd_entry)
	);

	// ========================================================================
	// Walk control
	// ========================================================================

	hpt_match_fsm u_match (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.probe      (probe),
		.vadr       (vadr),
		.cd_vadr    (cd_vadr),
		.last_probe (last_probe),
		.rd_en      (rd_en),
		.xlat       (xlat),
		.found      (found),
		.done       (done),
		.rsp        (rsp),
		.entry      (rd_entry)
	);

endmodule

//--- tb_hpt_lookup.sv
`timescale 1ns/1ps
`include "hpt_defines.svh"

module tb_hpt_lookup;
	import hpt_pkg::*;

	// One stimulus row with its expected walk result
	// A row with swap set starts on vadr_start and moves to vadr mid-walk
	typedef struct packed {
		logic      swap;
		vadr_t     vadr_start;
		vadr_t     vadr;
		bounce_t   max_bounce;
		walk_rsp_t exp;
	} test_row_t;

	localparam int NUM_ROWS = 11;
	// Every row may walk all 256 probes, plus the table load, the reset and slack
	localparam int CYCLE_LIMIT = NUM_ROWS * 2 * (255 + 1) + 256 + 5 + 400;

	logic       clk;
	logic       rst;
	logic       req;
	vadr_t      vadr;
	bounce_t    max_bounce;
	logic       tbl_we;
	hpt_index_t tbl_index;
	hpt_entry_t tbl_entry;
	logic       done;
	walk_rsp_t  rsp;

	// Model of the table contents and which slots hold a placed entry
	hpt_entry_t model [256];
	logic       used [256];
	test_row_t  rows [NUM_ROWS];

	logic [15:0] lfsr;
	int          cycles;
	int          cur_test;
	int          errors;
	int          failed_rows;

	hpt_lookup dut (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.vadr       (vadr),
		.max_bounce (max_bounce),
		.tbl_we     (tbl_we),
		.tbl_index  (tbl_index),
		.tbl_entry  (tbl_entry),
		.done       (done),
		.rsp        (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================================================
	// Random bits and the reference model
	// ========================================================================

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		logic [15:0] n;
		n = {1'b0, s[15:1]};
		if (s[0]) n = n ^ 16'hB400;
		return n;
	endfunction

	// Shifts out n bits, one LFSR step per bit
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return bits;
	endfunction

	// Home slot, XOR of the two low bytes and the zero extended top nibble
	function automatic hpt_index_t home_slot(vpn_t v);
		return v[7:0] ^ v[15:8] ^ {4'b0000, v[19:16]};
	endfunction

	// Linear probe insertion into the model, returns how far the entry was displaced
	function automatic int place(vpn_t v, ppn_t p, logic valid);
		hpt_index_t slot;
		int         k;
		slot = home_slot(v);
		k = 0;
		while (used[slot]) begin
			slot = slot + 8'd1;
			k++;
		end
		model[slot].valid = valid;
		model[slot].tag = v;
		model[slot].ppn = p;
		used[slot] = 1'b1;
		return k;
	endfunction

	// Walk the model table with probes 0 to mb
	function automatic walk_rsp_t model_walk(vadr_t a, bounce_t mb);
		walk_rsp_t  r;
		hpt_index_t idx;
		vpn_t       v;
		v = a[31:`HPT_PAGE_BITS];
		r = '0;
		r.fault = 1'b1;
		for (int k = 0; k <= int'(mb); k++) begin
			idx = home_slot(v) + hpt_index_t'(k);
			if (model[idx].valid && model[idx].tag == v && !r.hit) begin
				r.hit = 1'b1;
				r.fault = 1'b0;
				r.padr = {model[idx].ppn, a[`HPT_PAGE_BITS-1:0]};
			end
		end
		return r;
	endfunction

	// Random page offset on top of the page number
	function automatic test_row_t make_row(vpn_t v, bounce_t mb);
		test_row_t r;
		r = '0;
		r.vadr = {v, 12'(take_bits(12))};
		r.max_bounce = mb;
		r.exp = model_walk(r.vadr, mb);
		return r;
	endfunction

	// ========================================================================
	// Table contents and the row table
	// ========================================================================

	task automatic build_tests();
		vpn_t       v_home;
		vpn_t       v_disp;
		vpn_t       v_inv;
		vpn_t       v_abs;
		vpn_t       v_home2;
		vpn_t       t;
		hpt_index_t idx;
		int         d_disp;
		// Empty slots get an invalid filler that varies with the whole index
		for (int i = 0; i < 256; i++) begin
			idx = hpt_index_t'(i);
			model[i].valid = 1'b0;
			model[i].tag = {idx, ~idx, idx[3:0]};
			model[i].ppn = {~idx, idx, idx[7:4]};
			used[i] = 1'b0;
		end
		v_home = vpn_t'(take_bits(20));
		void'(place(v_home, ppn_t'(take_bits(20)), 1'b1));
		// Three valid strangers sit at the displaced VPN's home and the next slots
		v_disp = vpn_t'(take_bits(20));
		for (int j = 0; j < 3; j++) begin
			idx = home_slot(v_disp) + hpt_index_t'(j);
			t = vpn_t'(take_bits(20));
			if (t == v_disp) t = ~t;
			if (!used[idx]) begin
				model[idx] = '{valid: 1'b1, tag: t, ppn: ppn_t'(take_bits(20))};
				used[idx] = 1'b1;
			end
		end
		d_disp = place(v_disp, ppn_t'(take_bits(20)), 1'b1);
		// Tag matches but the entry is not valid, kept at its own home slot
		v_inv = vpn_t'(take_bits(20));
		while (used[home_slot(v_inv)]) begin
			v_inv = vpn_t'(take_bits(20));
		end
		void'(place(v_inv, ppn_t'(take_bits(20)), 1'b0));
		v_abs = vpn_t'(take_bits(20));
		// Second home VPN, drawn again until its home slot is free
		v_home2 = vpn_t'(take_bits(20));
		while (used[home_slot(v_home2)]) begin
			v_home2 = vpn_t'(take_bits(20));
		end
		void'(place(v_home2, ppn_t'(take_bits(20)), 1'b1));

		rows[0] = make_row(v_home, 8'd0);
		rows[1] = make_row(v_disp, bounce_t'(d_disp));
		rows[2] = make_row(v_disp, bounce_t'(d_disp + 4));
		rows[3] = make_row(v_disp, bounce_t'(d_disp - 1));
		rows[4] = make_row(v_abs, 8'd0);
		rows[5] = make_row(v_abs, 8'd9);
		rows[6] = make_row(v_inv, 8'd1);
		// Home hit straight after a run of faults
		rows[7] = make_row(v_home2, 8'd0);
		// A home hit abandoned in its first check for the displaced address
		rows[8] = make_row(v_disp, bounce_t'(d_disp));
		rows[8].swap = 1'b1;
		rows[8].vadr_start = {v_home, 12'(take_bits(12))};
		rows[9] = make_row(v_abs, 8'd255);
		rows[10] = make_row(v_home2, 8'd3);
	endtask

	task automatic load_table();
		for (int i = 0; i < 256; i++) begin
			@(negedge clk);
			tbl_we = 1'b1;
			tbl_index = hpt_index_t'(i);
			tbl_entry = model[i];
		end
		@(negedge clk);
		tbl_we = 1'b0;
	endtask

	// ========================================================================
	// Applying one row
	// ========================================================================

	task automatic run_row(int n);
		test_row_t r;
		walk_rsp_t got;
		int        dones;
		int        errs_before;
		r = rows[n];
		cur_test = n;
		errs_before = errors;
		@(negedge clk);
		vadr = r.swap ? r.vadr_start : r.vadr;
		max_bounce = r.max_bounce;
		req = 1'b1;
		@(negedge clk);
		req = 1'b0;
		if (r.swap) begin
			// The next falling edge sits in the first CHECK, where the old walk would hit
			@(negedge clk);
			vadr = r.vadr;
		end
		// The cycle counter ends the run if done never shows up
		while (!done) @(negedge clk);
		got = rsp;
		dones = 1;
		assert (got.hit == r.exp.hit)
			else begin
				$display("ERR %0t: row %0d hit %0b, expected %0b", $time, n, got.hit, r.exp.hit);
				errors++;
			end
		assert (got.fault == r.exp.fault)
			else begin
				$display("ERR %0t: row %0d fault %0b, expected %0b", $time, n, got.fault,
					r.exp.fault);
				errors++;
			end
		if (r.exp.hit) begin
			assert (got.padr == r.exp.padr)
				else begin
					$display("ERR %0t: row %0d padr %h, expected %h", $time, n, got.padr,
						r.exp.padr);
					errors++;
				end
		end
		// A second done for the same request would be a stray response
		repeat (4) begin
			@(negedge clk);
			if (done) dones++;
		end
		assert (dones == 1)
			else begin
				$display("ERR %0t: row %0d saw %0d done pulses, expected 1", $time, n, dones);
				errors++;
			end
		if (errors != errs_before) failed_rows++;
		$display("row %0d vadr %h max_bounce %0d: hit %0b fault %0b padr %h, %s", n, r.vadr,
			r.max_bounce, got.hit, got.fault, got.padr, (errors == errs_before) ? "ok" : "bad");
	endtask

	// ========================================================================
	// Main sequence and the watchdog
	// ========================================================================

	initial begin
		rst = 1'b1;
		req = 1'b0;
		vadr = '0;
		max_bounce = '0;
		tbl_we = 1'b0;
		tbl_index = '0;
		tbl_entry = '0;
		lfsr = 16'd51896;
		cur_test = -1;
		errors = 0;
		failed_rows = 0;
		build_tests();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		load_table();
		for (int n = 0; n < NUM_ROWS; n++) begin
			run_row(n);
		end
		$display("rows %0d, failing rows %0d, mismatches %0d", NUM_ROWS, failed_rows, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (cur_test < 0) begin
			$display("Timeout after %0d cycles, the table load never finished", cycles);
		end else begin
			$display("Timeout after %0d cycles, row %0d never reported done", cycles, cur_test);
		end
		$display("test failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+.
hpt_pkg.sv
ht_bounce_counter.sv
hpt_probe_gen.sv
hpt_table.sv
hpt_match_fsm.sv
hpt_lookup.sv
tb_hpt_lookup.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the HPT lookup testbench with Verilator, runs it and checks the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_hpt_lookup \
	-o tb_sim

out="$(./obj_dir/tb_sim)"
echo "$out"

if grep -qx "test passed" <<< "$out"; then
	exit 0
else
	exit 1
fi
